//--- src/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cpu side widths
`define ADDR_BITS 32
`define WORD_BITS 32
`define BLOCK_BITS 64

// address split: tag | index | word | byte
`define INDEX_LSB 3
`define INDEX_MSB 10
`define TAG_LSB 11

`define CACHE_SETS 256

// 4096 blocks, address bits 14:3
`define MEM_BLOCK_BITS 12
`define MEM_LATENCY 3   // request to ready, in cycles

`endif

//--- src/cache_types_pkg.sv
`include "cache_defines.svh"

package cache_types_pkg;

    // address bits 31 down to TAG_LSB
    typedef logic [`ADDR_BITS-`TAG_LSB-1:0] tag_t;

    // one line of the direct-mapped store
    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        tag_t                   tag;
        logic [`BLOCK_BITS-1:0] data;   // word 1 in the upper half
    } cache_line_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        COMPARE_TAG,
        WRITE_BACK,
        ALLOCATE
    } ctrl_state_t;

endpackage

//--- src/mem_bus_pkg.sv
package mem_bus_pkg;

    // cpu request kind
    typedef enum logic {
        CPU_READ  = 1'b0,
        CPU_WRITE = 1'b1
    } cpu_op_t;

    // memory request kind, always a whole block
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

endpackage

//--- src/cache_line_store.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_line_store (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [`INDEX_MSB-`INDEX_LSB:0]     rd_index,
    output cache_types_pkg::cache_line_t       rd_line,
    input  logic                               wr_en,
    input  logic [`INDEX_MSB-`INDEX_LSB:0]     wr_index,
    input  cache_types_pkg::cache_line_t       wr_line
);
    import cache_types_pkg::*;

    logic [`CACHE_SETS-1:0] valid_q;
    logic                   dirty_mem [`CACHE_SETS];
    tag_t                   tag_mem [`CACHE_SETS];
    logic [`BLOCK_BITS-1:0] data_mem [`CACHE_SETS];

    // valid bits live in flops so reset can clear all sets at once
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= wr_line.valid;
        end
    end

    // ram-like arrays
    always_ff @(posedge clk) begin
        if (wr_en) begin
            dirty_mem[wr_index] <= wr_line.dirty;
            tag_mem[wr_index]   <= wr_line.tag;
            data_mem[wr_index]  <= wr_line.data;
        end
    end

    // async read, same-cycle line for the tag compare
    assign rd_line = '{
        valid: valid_q[rd_index],
        dirty: dirty_mem[rd_index],
        tag:   tag_mem[rd_index],
        data:  data_mem[rd_index]
    };

endmodule

//--- src/cache_controller.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_controller (
    input  logic                               clk,
    input  logic                               rst,

    // cpu port
    input  logic                               cpu_valid,
    input  mem_bus_pkg::cpu_op_t               cpu_op,
    input  logic [`ADDR_BITS-1:0]              cpu_addr,
    input  logic [`WORD_BITS-1:0]              cpu_wdata,
    output logic                               cpu_ready,
    output logic [`WORD_BITS-1:0]              cpu_rdata,

    // memory port, block addressed
    output logic                               mem_valid,
    output mem_bus_pkg::mem_op_t               mem_op,
    output logic [`ADDR_BITS-`INDEX_LSB-1:0]   mem_addr,
    output logic [`BLOCK_BITS-1:0]             mem_wdata,
    input  logic                               mem_ready,
    input  logic [`BLOCK_BITS-1:0]             mem_rdata,

    // line store
    output logic [`INDEX_MSB-`INDEX_LSB:0]     rd_index,
    input  cache_types_pkg::cache_line_t       rd_line,
    output logic                               wr_en,
    output logic [`INDEX_MSB-`INDEX_LSB:0]     wr_index,
    output cache_types_pkg::cache_line_t       wr_line
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    tag_t                              req_tag;
    logic [`INDEX_MSB-`INDEX_LSB:0]    req_index;
    logic                              word_sel;
    logic                              hit;
    logic                              victim_dirty;
    logic [`WORD_BITS-1:0]             lo_word;
    logic [`WORD_BITS-1:0]             hi_word;

    assign req_tag   = cpu_addr[`ADDR_BITS-1:`TAG_LSB];
    assign req_index = cpu_addr[`INDEX_MSB:`INDEX_LSB];
    assign word_sel  = cpu_addr[`INDEX_LSB-1];   // addr bit 2

    // one set is looked up and written per request
    assign rd_index = req_index;
    assign wr_index = req_index;

    assign hit          = rd_line.valid && (rd_line.tag == req_tag);
    assign victim_dirty = rd_line.valid && rd_line.dirty;

    assign lo_word = rd_line.data[`WORD_BITS-1:0];
    assign hi_word = rd_line.data[`BLOCK_BITS-1:`WORD_BITS];

    assign cpu_rdata = word_sel ? hi_word : lo_word;

    // request is a function of state only, so it holds until mem_ready
    assign mem_valid = (state == WRITE_BACK) || (state == ALLOCATE);
    assign mem_op    = (state == WRITE_BACK) ? MEM_WRITE : MEM_READ;
    assign mem_wdata = rd_line.data;

    // victim address rebuilt from the stored tag
    always_comb begin
        if (state == WRITE_BACK) begin
            mem_addr = {rd_line.tag, req_index};
        end else begin
            mem_addr = cpu_addr[`ADDR_BITS-1:`INDEX_LSB];
        end
    end

    always_comb begin
        next_state = state;
        cpu_ready  = 1'b0;
        wr_en      = 1'b0;
        wr_line    = rd_line;

        case (state)
            IDLE: begin
                if (cpu_valid) begin
                    next_state = COMPARE_TAG;
                end
            end

            COMPARE_TAG: begin
                if (hit) begin
                    cpu_ready  = 1'b1;
                    next_state = IDLE;
                    if (cpu_op == CPU_WRITE) begin
                        wr_en         = 1'b1;
                        wr_line.dirty = 1'b1;
                        if (word_sel) begin
                            wr_line.data = {cpu_wdata, lo_word};
                        end else begin
                            wr_line.data = {hi_word, cpu_wdata};
                        end
                    end
                end else if (victim_dirty) begin
                    next_state = WRITE_BACK;
                end else begin
                    next_state = ALLOCATE;
                end
            end

            WRITE_BACK: begin
                if (mem_ready) begin
                    next_state = ALLOCATE;   // fill read issued from here
                end
            end

            ALLOCATE: begin
                if (mem_ready) begin
                    wr_en         = 1'b1;
                    wr_line.valid = 1'b1;
                    wr_line.dirty = 1'b0;
                    wr_line.tag   = req_tag;
                    wr_line.data  = mem_rdata;
                    next_state    = COMPARE_TAG;   // retry, now a hit
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- src/backing_memory.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module backing_memory (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               mem_valid,
    input  mem_bus_pkg::mem_op_t               mem_op,
    input  logic [`ADDR_BITS-`INDEX_LSB-1:0]   mem_addr,
    input  logic [`BLOCK_BITS-1:0]             mem_wdata,
    output logic                               mem_ready,
    output logic [`BLOCK_BITS-1:0]             mem_rdata
);
    import mem_bus_pkg::*;

    localparam int DEPTH    = 1 << `MEM_BLOCK_BITS;
    localparam int CNT_BITS = $clog2(`MEM_LATENCY + 1);
    localparam logic [`WORD_BITS-1:0] INIT_MASK = 32'hA5A50000;

    logic [`BLOCK_BITS-1:0]     mem_array [DEPTH];
    logic [`MEM_BLOCK_BITS-1:0] blk;
    logic [CNT_BITS-1:0]        wait_cnt;
    logic                       last_wait;

    assign blk = mem_addr[`MEM_BLOCK_BITS-1:0];   // upper block bits alias

    // each word starts as its byte address xor the mask
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_array[i] = {`WORD_BITS'(i * 8 + 4) ^ INIT_MASK,
                            `WORD_BITS'(i * 8) ^ INIT_MASK};
        end
    end

    // final wait cycle of the current request
    assign last_wait = mem_valid && !mem_ready &&
                       (wait_cnt == CNT_BITS'(`MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt  <= '0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= last_wait;
            if (last_wait || mem_ready) begin
                wait_cnt <= '0;   // back to idle after each ready
            end else if (mem_valid) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // access happens on the edge that raises ready
    always_ff @(posedge clk) begin
        if (last_wait) begin
            if (mem_op == MEM_WRITE) begin
                mem_array[blk] <= mem_wdata;
            end
            mem_rdata <= mem_array[blk];
        end
    end

endmodule

//--- src/cache_subsystem.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_subsystem (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cpu_valid,
    input  mem_bus_pkg::cpu_op_t    cpu_op,
    input  logic [`ADDR_BITS-1:0]   cpu_addr,
    input  logic [`WORD_BITS-1:0]   cpu_wdata,
    output logic                    cpu_ready,
    output logic [`WORD_BITS-1:0]   cpu_rdata
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    logic                               mem_valid;
    mem_op_t                            mem_op;
    logic [`ADDR_BITS-`INDEX_LSB-1:0]   mem_addr;
    logic [`BLOCK_BITS-1:0]             mem_wdata;
    logic                               mem_ready;
    logic [`BLOCK_BITS-1:0]             mem_rdata;

    logic [`INDEX_MSB-`INDEX_LSB:0]     rd_index;
    cache_line_t                        rd_line;
    logic                               wr_en;
    logic [`INDEX_MSB-`INDEX_LSB:0]     wr_index;
    cache_line_t                        wr_line;

    cache_controller u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .mem_valid (mem_valid),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .rd_index  (rd_index),
        .rd_line   (rd_line),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_line   (wr_line)
    );

    cache_line_store u_store (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .rd_line  (rd_line),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_line  (wr_line)
    );

    backing_memory u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- verif/cache_properties.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_properties (
    input logic                               clk,
    input logic                               rst,
    input cache_types_pkg::ctrl_state_t       state,
    input logic                               cpu_ready,
    input logic                               mem_valid,
    input mem_bus_pkg::mem_op_t               mem_op,
    input logic [`ADDR_BITS-`INDEX_LSB-1:0]   mem_addr,
    input logic [`BLOCK_BITS-1:0]             mem_wdata,
    input logic                               mem_ready
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    int unsigned assert_fails = 0;   // read by the testbench at the end

    ready_single_cycle: assert property (@(posedge clk) disable iff (rst)
        cpu_ready |=> !cpu_ready)
        else begin
            assert_fails++;
            $error("cpu_ready high for two cycles in a row");
        end

    no_mem_req_in_idle: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE) |-> !mem_valid)
        else begin
            assert_fails++;
            $error("mem_valid high while the controller is idle");
        end

    // request held until the ready pulse
    mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_valid && !mem_ready) |=>
            ($stable(mem_op) && $stable(mem_addr) && $stable(mem_wdata)))
        else begin
            assert_fails++;
            $error("memory request changed before mem_ready");
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!cpu_ready && !mem_valid))
        else begin
            assert_fails++;
            $error("cpu_ready or mem_valid high right after reset");
        end

endmodule

//--- verif/cache_tb.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_tb;
    import mem_bus_pkg::*;

    localparam int CYCLE_LIMIT = 6000;   // ~230 requests at ~20 cycles worst case
    localparam logic [`WORD_BITS-1:0] INIT_MASK = 32'hA5A50000;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   cpu_valid;
    cpu_op_t                cpu_op;
    logic [`ADDR_BITS-1:0]  cpu_addr;
    logic [`WORD_BITS-1:0]  cpu_wdata;
    logic                   cpu_ready;
    logic [`WORD_BITS-1:0]  cpu_rdata;

    logic [`WORD_BITS-1:0]  model_mem [logic [`ADDR_BITS-1:0]];   // written words only
    int                     error_count = 0;
    int                     check_count = 0;
    int                     test_errors_at_start;
    int                     test_checks_at_start;
    int                     cycle_count = 0;

    cache_subsystem UUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata)
    );

    bind cache_controller cache_properties u_props (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .cpu_ready (cpu_ready),
        .mem_valid (mem_valid),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready)
    );

    always #20 clk = ~clk;

    // expected word: last write, else byte address xor mask
    function automatic logic [`WORD_BITS-1:0] ref_read(input logic [`ADDR_BITS-1:0] addr);
        logic [`ADDR_BITS-1:0] waddr;
        waddr = {addr[`ADDR_BITS-1:2], 2'b00};
        if (model_mem.exists(waddr)) begin
            return model_mem[waddr];
        end
        return waddr ^ INIT_MASK;
    endfunction

    // read data compared on every read's ready pulse
    always @(negedge clk) begin
        if (!rst && cpu_ready && cpu_op == CPU_READ) begin
            check_count++;
            assert (cpu_rdata == ref_read(cpu_addr)) else begin
                $display("CHECK FAILED cpu_rdata addr 0x%08h expected 0x%08h got 0x%08h",
                         cpu_addr, ref_read(cpu_addr), cpu_rdata);
                error_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: no end of test after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // one request, returns falling edges until ready was seen
    task automatic do_request(input cpu_op_t op, input logic [`ADDR_BITS-1:0] addr,
                              input logic [`WORD_BITS-1:0] wdata, output int edges);
        int n;
        cpu_valid = 1'b1;
        cpu_op    = op;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        @(negedge clk);
        n = 1;
        while (!cpu_ready) begin
            @(negedge clk);
            n++;
        end
        edges = n;
        if (op == CPU_WRITE) begin
            model_mem[{addr[`ADDR_BITS-1:2], 2'b00}] = wdata;
        end
        @(posedge clk);
        #2 cpu_valid = 1'b0;   // one idle cycle between requests
        @(posedge clk);
        #2;
    endtask

    task automatic start_test();
        test_errors_at_start = error_count;
        test_checks_at_start = check_count;
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 check_count - test_checks_at_start, error_count - test_errors_at_start);
    endtask

    initial begin
        int                    edges;
        int                    seed_dummy;
        logic [`ADDR_BITS-1:0] addr;
        logic [`ADDR_BITS-1:0] set_sel;
        logic [`ADDR_BITS-1:0] tag_sel;
        logic [`ADDR_BITS-1:0] word_sel;
        logic [`WORD_BITS-1:0] wdata;
        int                    total_errors;

        seed_dummy = $urandom(32'h462f);
        rst       = 1'b1;
        cpu_valid = 1'b0;
        cpu_op    = CPU_READ;
        cpu_addr  = '0;
        cpu_wdata = '0;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
        @(posedge clk);
        #2;

        start_test();
        for (int k = 0; k < 8; k++) begin
            do_request(CPU_READ, k * 32'h114, '0, edges);   // eight distinct sets
        end
        report_test("cold_reads");

        start_test();
        for (int k = 0; k < 2; k++) begin
            do_request(CPU_READ, 32'h114, '0, edges);
            check_count++;
            assert (edges == 2) else begin
                $display("CHECK FAILED cpu_ready latency expected 0x2 got 0x%0h", edges);
                error_count++;
            end
        end
        report_test("hit_latency");

        start_test();
        do_request(CPU_WRITE, 32'h2A0, 32'h12345678, edges);
        do_request(CPU_READ, 32'h2A4, '0, edges);   // upper word still initial
        do_request(CPU_WRITE, 32'h2A4, 32'h9ABCDEF0, edges);
        do_request(CPU_READ, 32'h2A0, '0, edges);
        do_request(CPU_READ, 32'h2A4, '0, edges);
        report_test("word_select");

        start_test();
        do_request(CPU_WRITE, 32'h3A8, 32'hDEADBEEF, edges);
        do_request(CPU_READ, 32'hBA8, '0, edges);   // same set, other tag
        do_request(CPU_READ, 32'h3A8, '0, edges);
        do_request(CPU_READ, 32'h3AC, '0, edges);
        report_test("dirty_eviction");

        start_test();
        for (int i = 0; i < 200; i++) begin
            set_sel  = $urandom % 16;
            tag_sel  = $urandom % 4;
            word_sel = $urandom % 2;
            wdata    = $urandom;
            addr     = (tag_sel << 11) | (set_sel << 3) | (word_sel << 2);
            if ($urandom % 2 == 1) begin
                do_request(CPU_WRITE, addr, wdata, edges);
            end else begin
                do_request(CPU_READ, addr, '0, edges);
            end
        end
        report_test("random_mix");

        total_errors = error_count + UUT.u_ctrl.u_props.assert_fails;
        $display("totals: %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, UUT.u_ctrl.u_props.assert_fails);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+src
src/cache_types_pkg.sv
src/mem_bus_pkg.sv
src/cache_line_store.sv
src/cache_controller.sv
src/backing_memory.sv
src/cache_subsystem.sv
verif/cache_properties.sv
verif/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f filelist.f --top-module cache_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vcache_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
